/* hdl/ahb_params.svh */
`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// ********************************************************************
// bus geometry
// ********************************************************************

`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32
`define AHB_STRB_WIDTH 4   // one lane per byte of the data bus

// ********************************************************************
// memory map
// ********************************************************************

`define MEM_BANK_WORDS 256   // 1 KiB per bank
`define MEM_BANK_BIT   10    // the bank is picked by this byte address bit
`define MEM_SIZE_BYTES 2048  // decoded region starts at address zero
`define MEM_NUM_BANKS  2

`endif

/* hdl/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

`include "ahb_params.svh"

    // ****************************************************************
    // AHB encodings
    // ****************************************************************

    typedef enum logic [1:0] {
        AHB_TRANS_IDLE   = 2'b00,
        AHB_TRANS_BUSY   = 2'b01,
        AHB_TRANS_NONSEQ = 2'b10,
        AHB_TRANS_SEQ    = 2'b11
    } ahb_trans_e;

    typedef enum logic [2:0] {
        AHB_SIZE_BYTE = 3'b000,
        AHB_SIZE_HALF = 3'b001,
        AHB_SIZE_WORD = 3'b010   // widest transfer the bus carries
    } ahb_size_e;

    typedef enum logic {
        AHB_RESP_OKAY  = 1'b0,
        AHB_RESP_ERROR = 1'b1
    } ahb_resp_e;

    // ****************************************************************
    // bus and memory-side bundles
    // ****************************************************************

    typedef struct packed {
        logic                       hsel;
        logic [`AHB_ADDR_WIDTH-1:0] haddr;
        ahb_trans_e                 htrans;
        ahb_size_e                  hsize;
        logic                       hwrite;
        logic [`AHB_DATA_WIDTH-1:0] hwdata;  // belongs to the data phase
    } ahb_req_t;

    typedef struct packed {
        logic [`AHB_DATA_WIDTH-1:0] hrdata;
        logic                       hready;
        ahb_resp_e                  hresp;
    } ahb_rsp_t;

    typedef struct packed {
        logic                       en;
        logic [`AHB_ADDR_WIDTH-1:0] addr;    // byte address
        logic [`AHB_DATA_WIDTH-1:0] data;
        logic [`AHB_STRB_WIDTH-1:0] byteen;
    } mif_wr_t;

    typedef struct packed {
        logic                       en;
        logic [`AHB_ADDR_WIDTH-1:0] addr;    // byte address
    } mif_rd_t;

endpackage

`default_nettype wire

/* hdl/ahb_bank_decoder.sv */
`default_nettype none

`include "ahb_params.svh"

module ahb_bank_decoder import ahb_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  ahb_req_t req,
    input  ahb_rsp_t bank_rsp [`MEM_NUM_BANKS],

    output ahb_req_t bank_req [`MEM_NUM_BANKS],
    output ahb_rsp_t rsp
);

    localparam int BANK_BITS = $clog2(`MEM_NUM_BANKS);

    logic                      in_region;
    logic                      xfer;
    logic [`MEM_NUM_BANKS-1:0] bank_sel;
    logic [`MEM_NUM_BANKS-1:0] owner_q;   // one-hot owner of the current data phase

    // ****************************************************************
    // address phase decode
    // ****************************************************************

    assign in_region = (req.haddr < `MEM_SIZE_BYTES);

    always_comb begin
        case (req.htrans)
            AHB_TRANS_NONSEQ,
            AHB_TRANS_SEQ: begin
                xfer = 1'b1;
            end
            default: begin
                xfer = 1'b0;   // idle and busy carry no transfer
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            bank_sel[b] = req.hsel && in_region
                       && (req.haddr[`MEM_BANK_BIT +: BANK_BITS] == BANK_BITS'(b));
        end
    end

    // each bank sees the whole request with only its own select
    always_comb begin
        for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            bank_req[b]      = req;
            bank_req[b].hsel = bank_sel[b];
        end
    end

    // ****************************************************************
    // data phase ownership and read mux
    // ****************************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= '0;
        end else begin
            owner_q <= xfer ? bank_sel : '0;   // out-of-region transfers own nothing
        end
    end

    always_comb begin
        rsp = '{hrdata: '0, hready: 1'b1, hresp: AHB_RESP_OKAY};   // reads as zero
        for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            if (owner_q[b]) begin
                rsp = bank_rsp[b];
            end
        end
    end

    // owner_q moves on every cycle and cannot hold a stalled data phase
    a_owner_ready: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (owner_q != '0) |-> rsp.hready
    );

endmodule

`default_nettype wire

/* hdl/ahb2mif.sv */
`default_nettype none

`include "ahb_params.svh"

module ahb2mif import ahb_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  ahb_req_t                   req,
    input  logic [`AHB_DATA_WIDTH-1:0] rd_data,

    output ahb_rsp_t                   rsp,
    output mif_wr_t                    wr,
    output mif_rd_t                    rd
);

    localparam int LANE_BITS = $clog2(`AHB_STRB_WIDTH);

    logic                       active;
    logic                       wr_start;
    logic                       wr_en_q;
    logic [`AHB_ADDR_WIDTH-1:0] wr_addr_q;
    logic [`AHB_STRB_WIDTH-1:0] wr_byteen_q;

    // lanes covered by a transfer of the given size at the given offset
    function automatic logic [`AHB_STRB_WIDTH-1:0] lane_mask(
        input ahb_size_e            size,
        input logic [LANE_BITS-1:0] offset
    );
        logic [`AHB_STRB_WIDTH-1:0] mask;
        int                         lanes;
        int                         first;

        lanes = 1 << size;
        first = int'(offset);
        for (int j = 0; j < `AHB_STRB_WIDTH; j++) begin
            mask[j] = (j >= first) && (j < first + lanes);
        end
        return mask;
    endfunction

    // ****************************************************************
    // address phase
    // ****************************************************************

    always_comb begin
        case (req.htrans)
            AHB_TRANS_NONSEQ,
            AHB_TRANS_SEQ: begin
                active = req.hsel;
            end
            default: begin
                active = 1'b0;
            end
        endcase
    end

    assign wr_start = active && req.hwrite;

    // reads go to the RAM straight from the address phase
    assign rd = '{en: active && !req.hwrite, addr: req.haddr};

    // ****************************************************************
    // write data phase
    // ****************************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_en_q     <= 1'b0;
            wr_byteen_q <= '0;
        end else begin
            wr_en_q     <= wr_start;
            wr_byteen_q <= wr_start ? lane_mask(req.hsize, req.haddr[LANE_BITS-1:0]) : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_start) begin
            wr_addr_q <= req.haddr;
        end
    end

    // hwdata arrives in the cycle after the address was captured
    assign wr = '{en: wr_en_q, addr: wr_addr_q, data: req.hwdata, byteen: wr_byteen_q};

    // the slave never stalls and never errors
    assign rsp = '{hrdata: rd_data, hready: 1'b1, hresp: AHB_RESP_OKAY};

    a_size_max_word: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        active |-> (req.hsize <= AHB_SIZE_WORD)
    );

    // Misaligned transfers would spill lanes past the word and be truncated.
    a_addr_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        active |-> ((req.haddr[LANE_BITS-1:0] & ((1 << req.hsize) - 1)) == 0)
    );

endmodule

`default_nettype wire

/* hdl/mif_sram.sv */
`default_nettype none

`include "ahb_params.svh"

module mif_sram import ahb_pkg::*; (
    input  logic                       clk_i,

    input  mif_wr_t                    wr,
    input  mif_rd_t                    rd,

    output logic [`AHB_DATA_WIDTH-1:0] rd_data
);

    localparam int LANE_BITS  = $clog2(`AHB_STRB_WIDTH);
    localparam int INDEX_BITS = $clog2(`MEM_BANK_WORDS);

    logic [`AHB_STRB_WIDTH-1:0][7:0] mem [`MEM_BANK_WORDS];

    logic [INDEX_BITS-1:0]           wr_index;
    logic [INDEX_BITS-1:0]           rd_index;
    logic [`AHB_STRB_WIDTH-1:0][7:0] wr_lanes;
    logic [`AHB_STRB_WIDTH-1:0][7:0] rd_merge;
    logic [`AHB_STRB_WIDTH-1:0][7:0] rd_q;
    logic                            same_word;

    assign wr_index = wr.addr[`MEM_BANK_BIT-1:LANE_BITS];   // bank bit and above are dropped
    assign rd_index = rd.addr[`MEM_BANK_BIT-1:LANE_BITS];
    assign wr_lanes = wr.data;

    // ****************************************************************
    // write port
    // ****************************************************************

    always_ff @(posedge clk_i) begin
        if (wr.en) begin
            for (int j = 0; j < `AHB_STRB_WIDTH; j++) begin
                if (wr.byteen[j]) begin
                    mem[wr_index][j] <= wr_lanes[j];
                end
            end
        end
    end

    // ****************************************************************
    // read port with write forwarding
    // ****************************************************************

    assign same_word = wr.en && (wr_index == rd_index);

    always_comb begin
        rd_merge = mem[rd_index];
        for (int j = 0; j < `AHB_STRB_WIDTH; j++) begin
            if (same_word && wr.byteen[j]) begin
                rd_merge[j] = wr_lanes[j];   // take the lane being written this cycle
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd.en) begin
            rd_q <= rd_merge;
        end
    end

    assign rd_data = rd_q;

    // An unknown lane mask would corrupt storage and the forwarded read alike.
    a_byteen_known: assert property (
        @(posedge clk_i) wr.en |-> !$isunknown(wr.byteen)
    );

endmodule

`default_nettype wire

/* hdl/ahb_mem_top.sv */
`default_nettype none

`include "ahb_params.svh"

module ahb_mem_top import ahb_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  ahb_req_t ahb_req,
    output ahb_rsp_t ahb_rsp
);

    ahb_req_t                   bank_req     [`MEM_NUM_BANKS];
    ahb_rsp_t                   bank_rsp     [`MEM_NUM_BANKS];
    mif_wr_t                    bank_wr      [`MEM_NUM_BANKS];
    mif_rd_t                    bank_rd      [`MEM_NUM_BANKS];
    logic [`AHB_DATA_WIDTH-1:0] bank_rd_data [`MEM_NUM_BANKS];

    // ****************************************************************
    // bank decode
    // ****************************************************************

    ahb_bank_decoder i_ahb_bank_decoder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req      (ahb_req),
        .bank_rsp (bank_rsp),
        .bank_req (bank_req),
        .rsp      (ahb_rsp)
    );

    // ****************************************************************
    // per-bank bridge and RAM
    // ****************************************************************

    for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : gen_bank

        ahb2mif i_ahb2mif (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req     (bank_req[b]),
            .rd_data (bank_rd_data[b]),
            .rsp     (bank_rsp[b]),
            .wr      (bank_wr[b]),
            .rd      (bank_rd[b])
        );

        mif_sram i_mif_sram (
            .clk_i   (clk_i),
            .wr      (bank_wr[b]),
            .rd      (bank_rd[b]),
            .rd_data (bank_rd_data[b])   // registered, valid in the data phase
        );

    end

endmodule

`default_nettype wire

/* testbench/tb_ahb_mem.sv */
`default_nettype none

`include "ahb_params.svh"

module tb_ahb_mem import ahb_pkg::*; ();

    localparam ahb_trans_e ID = AHB_TRANS_IDLE;
    localparam ahb_trans_e BS = AHB_TRANS_BUSY;
    localparam ahb_trans_e NS = AHB_TRANS_NONSEQ;
    localparam ahb_trans_e SQ = AHB_TRANS_SEQ;
    localparam ahb_size_e  SB = AHB_SIZE_BYTE;
    localparam ahb_size_e  SH = AHB_SIZE_HALF;
    localparam ahb_size_e  SW = AHB_SIZE_WORD;

    localparam int RESET_CYCLES   = 10;
    localparam int RESET_TIMEOUT  = 50;
    localparam int WATCHDOG_TIME  = 50000;
    localparam int MEM_WORDS      = `MEM_SIZE_BYTES / `AHB_STRB_WIDTH;

    typedef struct {
        string                      name;
        logic                       hsel;
        ahb_trans_e                 htrans;
        logic                       hwrite;
        ahb_size_e                  hsize;
        logic [`AHB_ADDR_WIDTH-1:0] addr;
        logic [`AHB_DATA_WIDTH-1:0] wdata;
        logic                       check;
    } vector_t;

    logic     clk_i;
    logic     rst_n_i;
    ahb_req_t ahb_req;
    ahb_rsp_t ahb_rsp;

    logic [7:0] model [`MEM_SIZE_BYTES];   // byte image of the whole region
    vector_t    vectors [$];
    integer     seed = 32'h7ec22ae5;
    int         errors = 0;
    int         checks = 0;

    // the transfer whose data phase is in flight
    string                      pend_name  = "";
    logic                       pend_check = 1'b0;
    logic [`AHB_DATA_WIDTH-1:0] pend_exp   = '0;
    logic [`AHB_DATA_WIDTH-1:0] pend_wdata = '0;

    ahb_mem_top i_ahb_mem_top (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ahb_req (ahb_req),
        .ahb_rsp (ahb_rsp)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    initial begin
        rst_n_i = 1'b0;
        ahb_req = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("simulation ran out of time before all transfers completed");
        $display("=== FAIL ===");
        $finish;
    end

    // ********************************************************************
    // checking and reference model
    // ********************************************************************

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    function automatic logic [`AHB_DATA_WIDTH-1:0] model_word(input logic [31:0] addr);
        int base;

        base = int'({addr[31:2], 2'b00});
        return {model[base + 3], model[base + 2], model[base + 1], model[base]};
    endfunction

    // only the lanes named by size and offset take bytes from the bus
    task automatic model_write(input ahb_size_e size, input logic [31:0] addr,
                               input logic [31:0] data);
        int lanes;
        int off;

        lanes = 1 << size;
        off   = int'(addr[1:0]);
        for (int k = 0; k < lanes; k++) begin
            model[int'(addr) + k] = data[8 * (off + k) +: 8];
        end
    endtask

    // ********************************************************************
    // one pipelined bus cycle
    // ********************************************************************

    task automatic apply_step(input string name, input logic hsel, input ahb_trans_e htrans,
                              input logic hwrite, input ahb_size_e hsize,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic check);
        logic                       xfer;
        logic [`AHB_DATA_WIDTH-1:0] exp;

        @(posedge clk_i);
        #1;
        ahb_req.hsel   = hsel;
        ahb_req.haddr  = addr;
        ahb_req.htrans = htrans;
        ahb_req.hsize  = hsize;
        ahb_req.hwrite = hwrite;
        ahb_req.hwdata = pend_wdata;   // data phase of the previous transfer
        xfer = hsel && (htrans == NS || htrans == SQ) && (addr < `MEM_SIZE_BYTES);
        exp  = (xfer && !hwrite) ? model_word(addr) : '0;
        if (xfer && hwrite) begin
            model_write(hsize, addr, wdata);
        end
        @(negedge clk_i);
        check_value("hready", 32'd1, 32'(ahb_rsp.hready));
        check_value("hresp", 32'(AHB_RESP_OKAY), 32'(ahb_rsp.hresp));
        if (pend_check) begin
            check_value(pend_name, pend_exp, ahb_rsp.hrdata);
        end
        pend_name  = name;
        pend_check = check;
        pend_exp   = exp;
        pend_wdata = wdata;
    endtask

    task automatic add_vector(input string name, input logic hsel, input ahb_trans_e htrans,
                              input logic hwrite, input ahb_size_e hsize,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic check);
        vector_t v;

        v = '{name, hsel, htrans, hwrite, hsize, addr, wdata, check};
        vectors.push_back(v);
    endtask

    task automatic build_vectors();
        // word access in both banks
        add_vector("b0_wr_word",      1, NS, 1, SW, 32'h010, 32'h11223344, 0);
        add_vector("b1_wr_word",      1, NS, 1, SW, 32'h410, 32'ha5a55a5a, 0);
        add_vector("b0_wr_word_again", 1, SQ, 1, SW, 32'h010, 32'hcafef00d, 0);
        add_vector("b1_wr_top",       1, NS, 1, SW, 32'h7fc, 32'h0badc0de, 0);
        add_vector("b0_wr_top",       1, NS, 1, SW, 32'h3fc, 32'h13579bdf, 0);
        add_vector("b0_rd_word",      1, NS, 0, SW, 32'h010, 32'h0, 1);
        add_vector("b1_rd_word",      1, SQ, 0, SW, 32'h410, 32'h0, 1);
        add_vector("b1_rd_top",       1, NS, 0, SW, 32'h7fc, 32'h0, 1);
        add_vector("b0_rd_top",       1, NS, 0, SW, 32'h3fc, 32'h0, 1);
        // byte and halfword lanes, bus carries junk on the other lanes
        add_vector("b0_wr_byte0",     1, NS, 1, SB, 32'h020, 32'hdeadbeef, 0);
        add_vector("b0_wr_byte1",     1, NS, 1, SB, 32'h025, 32'h01234567, 0);
        add_vector("b0_wr_byte2",     1, SQ, 1, SB, 32'h02a, 32'h89abcdef, 0);
        add_vector("b0_wr_byte3",     1, NS, 1, SB, 32'h02f, 32'hf0e1d2c3, 0);
        add_vector("b0_wr_half0",     1, NS, 1, SH, 32'h030, 32'h76543210, 0);
        add_vector("b0_wr_half2",     1, NS, 1, SH, 32'h036, 32'hfedcba98, 0);
        add_vector("b1_wr_byte1",     1, NS, 1, SB, 32'h431, 32'h5a5a5a5a, 0);
        add_vector("b1_wr_half2",     1, NS, 1, SH, 32'h43a, 32'h3c3c3c3c, 0);
        add_vector("b0_rd_byte0",     1, NS, 0, SW, 32'h020, 32'h0, 1);
        add_vector("b0_rd_byte1",     1, NS, 0, SW, 32'h024, 32'h0, 1);
        add_vector("b0_rd_byte2",     1, NS, 0, SW, 32'h028, 32'h0, 1);
        add_vector("b0_rd_byte3",     1, NS, 0, SW, 32'h02c, 32'h0, 1);
        add_vector("b0_rd_half0",     1, NS, 0, SW, 32'h030, 32'h0, 1);
        add_vector("b0_rd_half2",     1, NS, 0, SW, 32'h034, 32'h0, 1);
        add_vector("b1_rd_byte1",     1, NS, 0, SW, 32'h430, 32'h0, 1);
        add_vector("b1_rd_half2",     1, NS, 0, SW, 32'h438, 32'h0, 1);
        // write immediately followed by a read of the same word
        add_vector("b0_fwd_wr_word",  1, NS, 1, SW, 32'h040, 32'ha1b2c3d4, 0);
        add_vector("b0_fwd_rd_word",  1, NS, 0, SW, 32'h040, 32'h0, 1);
        add_vector("b0_fwd_wr_byte",  1, NS, 1, SB, 32'h042, 32'h55667788, 0);
        add_vector("b0_fwd_rd_byte",  1, NS, 0, SW, 32'h040, 32'h0, 1);
        add_vector("b1_fwd_wr_half",  1, NS, 1, SH, 32'h446, 32'h99aabbcc, 0);
        add_vector("b1_fwd_rd_half",  1, SQ, 0, SW, 32'h444, 32'h0, 1);
        add_vector("b0_wr_byte_a",    1, NS, 1, SB, 32'h048, 32'h000000e1, 0);
        add_vector("b0_wr_byte_b",    1, NS, 1, SB, 32'h049, 32'h0000e200, 0);
        add_vector("b0_fwd_rd_two",   1, NS, 0, SW, 32'h048, 32'h0, 1);
        // cycles that carry no transfer
        add_vector("b0_idle_wr",      1, ID, 1, SW, 32'h050, 32'hffffffff, 0);
        add_vector("b0_busy_wr",      1, BS, 1, SW, 32'h050, 32'heeeeeeee, 0);
        add_vector("b0_nosel_wr",     0, NS, 1, SW, 32'h050, 32'hdddddddd, 0);
        add_vector("b1_nosel_wr",     0, NS, 1, SW, 32'h460, 32'hcccccccc, 0);
        add_vector("b0_idle_rd",      1, ID, 0, SW, 32'h050, 32'h0, 1);
        add_vector("b0_nosel_rd",     0, NS, 0, SW, 32'h050, 32'h0, 1);
        add_vector("b0_rd_untouched", 1, NS, 0, SW, 32'h050, 32'h0, 1);
        add_vector("b1_rd_untouched", 1, NS, 0, SW, 32'h460, 32'h0, 1);
        // outside the decoded region
        add_vector("oor_wr_alias0",   1, NS, 1, SW, 32'h800, 32'h12121212, 0);
        add_vector("oor_wr_alias1",   1, NS, 1, SW, 32'hc10, 32'h34343434, 0);
        add_vector("oor_wr_high",     1, NS, 1, SB, 32'h80000003, 32'h56565656, 0);
        add_vector("oor_rd_alias0",   1, NS, 0, SW, 32'h800, 32'h0, 1);
        add_vector("oor_rd_alias1",   1, NS, 0, SW, 32'hc10, 32'h0, 1);
        add_vector("oor_rd_high",     1, NS, 0, SW, 32'hfffffffc, 32'h0, 1);
        add_vector("b0_rd_word0",     1, NS, 0, SW, 32'h000, 32'h0, 1);
        add_vector("b1_rd_after_oor", 1, NS, 0, SW, 32'h410, 32'h0, 1);
    endtask

    // ********************************************************************
    // main sequence
    // ********************************************************************

    initial begin
        int cycles;

        build_vectors();
        cycles = 0;
        while (rst_n_i !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("reset was never released");
                $display("=== FAIL ===");
                $finish;
            end
            @(posedge clk_i);
            cycles++;
        end

        for (int w = 0; w < MEM_WORDS; w++) begin   // known contents everywhere
            apply_step("prefill", 1, NS, 1, SW, w * 4, $random(seed), 0);
        end

        foreach (vectors[i]) begin
            apply_step(vectors[i].name, vectors[i].hsel, vectors[i].htrans,
                       vectors[i].hwrite, vectors[i].hsize, vectors[i].addr,
                       vectors[i].wdata, vectors[i].check);
        end

        // every word must still match, so stray writes anywhere show up here
        for (int w = 0; w < MEM_WORDS; w++) begin
            apply_step($sformatf("readback_%03h", w * 4), 1, NS, 0, SW, w * 4, 32'h0, 1);
        end
        apply_step("flush", 0, ID, 0, SW, 32'h0, 32'h0, 0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/ahb_pkg.sv
hdl/ahb_bank_decoder.sv
hdl/ahb2mif.sv
hdl/mif_sram.sv
hdl/ahb_mem_top.sv
testbench/tb_ahb_mem.sv
